// ==== files.f ====
logic/cache_pkg.sv
logic/cache_datapath.sv
logic/cache_controller.sv
logic/cache_csr.sv
logic/cache_top.sv
bench/mem_model.sv
bench/cache_tb.sv

// ==== bench/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;
    import cache_pkg::*;

    localparam int NUM_LINES = 16;
    localparam int IDX_W     = $clog2(NUM_LINES);
    localparam int TIMEOUT   = 200;    // Cycles allowed for any single wait

    typedef struct packed {
        logic              is_read;
        logic [WORD_W-1:0] rdata;
    } cpu_exp_t;

    logic               clk;
    logic               rst;
    logic               cpu_valid;
    cpu_req_t           cpu_req;
    logic               cpu_ready;
    logic               cpu_done;
    logic [WORD_W-1:0]  cpu_rdata;
    logic               mem_valid;
    mem_req_t           mem_req;
    logic               mem_ack;
    logic [BLOCK_W-1:0] mem_rdata;
    logic               csr_valid;
    logic               csr_write;
    logic [3:0]         csr_addr;
    logic [WORD_W-1:0]  csr_wdata;
    logic [WORD_W-1:0]  csr_rdata;

    // Shadow of the cache lines and of memory
    logic [ADDR_W-1:0]  line_ba    [NUM_LINES];
    logic [BLOCK_W-1:0] line_blk   [NUM_LINES];
    logic               line_valid [NUM_LINES];
    logic               line_dirty [NUM_LINES];
    logic [BLOCK_W-1:0] shadow_mem [logic [ADDR_W-1:0]];
    logic               cache_on;
    int unsigned        exp_hits;
    int unsigned        exp_misses;
    mem_req_t           exp_mem [$];
    cpu_exp_t           exp_cpu [$];
    integer             stim_seed = 20429;

    cache_top #(
        .NUM_LINES(NUM_LINES)
    ) cache_top_inst (
        .clk      (clk),
        .rst      (rst),
        .cpu_valid(cpu_valid),
        .cpu_req  (cpu_req),
        .cpu_ready(cpu_ready),
        .cpu_done (cpu_done),
        .cpu_rdata(cpu_rdata),
        .mem_valid(mem_valid),
        .mem_req  (mem_req),
        .mem_ack  (mem_ack),
        .mem_rdata(mem_rdata),
        .csr_valid(csr_valid),
        .csr_write(csr_write),
        .csr_addr (csr_addr),
        .csr_wdata(csr_wdata),
        .csr_rdata(csr_rdata)
    );

    mem_model mem_model_inst (
        .clk      (clk),
        .rst      (rst),
        .mem_valid(mem_valid),
        .mem_req  (mem_req),
        .mem_ack  (mem_ack),
        .mem_rdata(mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_equal(input logic [BLOCK_W-1:0] actual,
                               input logic [BLOCK_W-1:0] expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    // Same fill as the memory model, never-written blocks
    function automatic logic [BLOCK_W-1:0] initial_block(input logic [ADDR_W-1:0] ba);
        logic [BLOCK_W-1:0] blk;
        for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
            blk[i*WORD_W +: WORD_W] = (ba + 4*i) * 32'h9e37_79b9 + 32'h0bad_c0de;
        end
        return blk;
    endfunction

    function automatic logic [BLOCK_W-1:0] mem_block(input logic [ADDR_W-1:0] ba);
        return shadow_mem.exists(ba) ? shadow_mem[ba] : initial_block(ba);
    endfunction

    function automatic mem_req_t mem_op(input logic [ADDR_W-1:0] addr,
                                        input logic [BLOCK_W-1:0] wdata, input logic write);
        mem_req_t op;
        op.addr  = addr;
        op.wdata = wdata;
        op.write = write;
        return op;
    endfunction

    // Predicts hit, memory traffic and read data, and updates the shadow state
    function automatic logic [WORD_W-1:0] ref_access(input cpu_req_t req, output logic hit);
        logic [ADDR_W-1:0]  ba;
        logic [IDX_W-1:0]   idx;
        logic [WSEL_W-1:0]  sel;
        logic [BLOCK_W-1:0] blk;
        ba  = {req.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        idx = req.addr[OFFSET_W +: IDX_W];
        sel = req.addr[OFFSET_W-1:2];
        hit = cache_on && line_valid[idx] && (line_ba[idx] == ba);
        if (hit) begin
            exp_hits++;
        end else begin
            exp_misses++;
            if (cache_on && line_valid[idx] && line_dirty[idx]) begin
                exp_mem.push_back(mem_op(line_ba[idx], line_blk[idx], 1'b1));
                shadow_mem[line_ba[idx]] = line_blk[idx];
            end
            exp_mem.push_back(mem_op(ba, '0, 1'b0));
        end
        if (!cache_on) begin
            blk = mem_block(ba);   // Read-modify-write straight to memory
            if (req.write) begin
                shadow_mem[ba] = blk;
                shadow_mem[ba][sel*WORD_W +: WORD_W] = req.wdata;
                exp_mem.push_back(mem_op(ba, shadow_mem[ba], 1'b1));
            end
            return blk[sel*WORD_W +: WORD_W];
        end
        if (!hit) begin
            line_ba[idx]    = ba;
            line_blk[idx]   = mem_block(ba);
            line_valid[idx] = 1'b1;
            line_dirty[idx] = 1'b0;
        end
        if (req.write) begin
            line_blk[idx][sel*WORD_W +: WORD_W] = req.wdata;
            line_dirty[idx] = 1'b1;
        end
        return line_blk[idx][sel*WORD_W +: WORD_W];
    endfunction

    function automatic void ref_flush();
        for (int i = 0; i < NUM_LINES; i++) begin
            if (line_valid[i] && line_dirty[i]) begin
                exp_mem.push_back(mem_op(line_ba[i], line_blk[i], 1'b1));
                shadow_mem[line_ba[i]] = line_blk[i];
            end
            line_valid[i] = 1'b0;
            line_dirty[i] = 1'b0;
        end
    endfunction

    // Every finished memory transfer and CPU request against the prediction
    always @(negedge clk) begin : compare_results
        mem_req_t op;
        cpu_exp_t res;
        if (rst && mem_valid && mem_ack) begin
            if (exp_mem.size() == 0) begin
                $display("Unexpected memory request at %0t ns to %h", $time, mem_req.addr);
                stop_with_failure();
            end else begin
                op = exp_mem.pop_front();
                check_equal(mem_req.write, op.write, "memory request direction");
                check_equal(mem_req.addr, op.addr, "memory request address");
                if (op.write) begin
                    check_equal(mem_req.wdata, op.wdata, "memory write data");
                end
            end
        end
        if (rst && cpu_done) begin
            if (exp_cpu.size() == 0) begin
                $display("cpu_done at %0t ns with no request outstanding", $time);
                stop_with_failure();
            end else begin
                res = exp_cpu.pop_front();
                if (res.is_read) begin
                    check_equal(cpu_rdata, res.rdata, "read data");
                end
            end
        end
    end

    task automatic cpu_access(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] wdata,
                              input logic write);
        cpu_req_t req;
        cpu_exp_t res;
        logic     exp_hit;
        int       cycles;
        req.addr    = addr;
        req.wdata   = wdata;
        req.write   = write;
        res.is_read = !write;
        res.rdata   = ref_access(req, exp_hit);
        exp_cpu.push_back(res);
        cpu_req   = req;
        cpu_valid = 1'b1;
        cycles    = 0;
        @(negedge clk);
        while (!cpu_ready) begin
            if (cycles > TIMEOUT) begin
                $display("Timeout: request to %h was never accepted", addr);
                stop_with_failure();
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
        @(posedge clk);
        #1;
        cpu_valid = 1'b0;
        cycles    = 0;
        @(negedge clk);
        while (!cpu_done) begin
            if (cycles > TIMEOUT) begin
                $display("Timeout: request to %h never completed", addr);
                stop_with_failure();
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
        check_equal(cycles == 0, exp_hit, "hit in the cycle after acceptance");
        @(posedge clk);
        #1;
        check_equal(exp_mem.size(), 0, "memory requests still missing");
    endtask

    task automatic csr_write_reg(input logic [3:0] addr, input logic [WORD_W-1:0] data);
        csr_valid = 1'b1;
        csr_write = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        @(posedge clk);
        #1;
        csr_valid = 1'b0;
        csr_write = 1'b0;
    endtask

    task automatic csr_read_reg(input logic [3:0] addr, output logic [WORD_W-1:0] data);
        csr_valid = 1'b1;
        csr_write = 1'b0;
        csr_addr  = addr;
        @(negedge clk);
        data = csr_rdata;
        @(posedge clk);
        #1;
        csr_valid = 1'b0;
    endtask

    task automatic check_counters();
        logic [WORD_W-1:0] value;
        csr_read_reg(CSR_HITS, value);
        check_equal(value, exp_hits, "hit counter");
        csr_read_reg(CSR_MISSES, value);
        check_equal(value, exp_misses, "miss counter");
    endtask

    task automatic clear_counters();
        csr_write_reg(CSR_HITS, '0);
        csr_write_reg(CSR_MISSES, '0);
        exp_hits   = 0;
        exp_misses = 0;
    endtask

    task automatic run_flush();
        logic [WORD_W-1:0] status;
        int                cycles;
        ref_flush();
        csr_write_reg(CSR_CTRL, 32'h3);   // Keep enable, start flush
        status = '0;
        cycles = 0;
        while (!status[0]) begin
            if (cycles > TIMEOUT) begin
                $display("Timeout: flush never became busy");
                stop_with_failure();
            end else begin
                cycles++;
                csr_read_reg(CSR_STATUS, status);
            end
        end
        cycles = 0;
        while (status[0]) begin
            if (cycles > TIMEOUT) begin
                $display("Timeout: flush never finished");
                stop_with_failure();
            end else begin
                cycles++;
                csr_read_reg(CSR_STATUS, status);
            end
        end
        check_equal(exp_mem.size(), 0, "flush write-backs still missing");
    endtask

    initial begin : main_sequence
        logic [WORD_W-1:0] value;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
        logic [WORD_W-1:0] pick;
        rst        = 1'b0;
        cpu_valid  = 1'b0;
        cpu_req    = '0;
        csr_valid  = 1'b0;
        csr_write  = 1'b0;
        csr_addr   = '0;
        csr_wdata  = '0;
        cache_on   = 1'b1;
        exp_hits   = 0;
        exp_misses = 0;
        for (int i = 0; i < NUM_LINES; i++) begin
            line_ba[i]    = '0;
            line_blk[i]   = '0;
            line_valid[i] = 1'b0;
            line_dirty[i] = 1'b0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;
        check_equal(cpu_ready, 1'b1, "cpu_ready after reset");
        check_equal(cpu_done, 1'b0, "cpu_done after reset");
        check_equal(mem_valid, 1'b0, "mem_valid after reset");
        csr_read_reg(CSR_STATUS, value);
        check_equal(value, 32'h0, "flush status after reset");
        csr_read_reg(CSR_CTRL, value);
        check_equal(value, 32'h1, "enable after reset");

        cpu_access(32'h0000_1004, '0, 1'b0);  // Miss, then hit in the same block
        cpu_access(32'h0000_1008, '0, 1'b0);
        check_counters();

        cpu_access(32'h0000_1008, 32'hdead_beef, 1'b1);
        cpu_access(32'h0000_1008, '0, 1'b0);

        // Same index, other tag
        cpu_access(32'h0000_2000, '0, 1'b0);
        cpu_access(32'h0000_1008, '0, 1'b0);

        cpu_access(32'h0000_3050, 32'h1111_0001, 1'b1);
        cpu_access(32'h0000_30a4, 32'h2222_0002, 1'b1);
        cpu_access(32'h0000_30c8, '0, 1'b0);
        run_flush();
        cpu_access(32'h0000_3050, '0, 1'b0);
        cpu_access(32'h0000_30c8, '0, 1'b0);
        cpu_access(32'h0000_1008, '0, 1'b0);
        check_counters();

        // Cache disabled
        csr_write_reg(CSR_CTRL, 32'h0);
        cache_on = 1'b0;
        clear_counters();
        cpu_access(32'h0000_4014, '0, 1'b0);
        cpu_access(32'h0000_4014, 32'h5555_aaaa, 1'b1);
        cpu_access(32'h0000_4014, '0, 1'b0);
        cpu_access(32'h0000_3050, '0, 1'b0);
        check_counters();
        csr_write_reg(CSR_CTRL, 32'h1);
        cache_on = 1'b1;

        // Four tags over all indexes and words
        for (int i = 0; i < 300; i++) begin
            addr  = 32'h0001_0000 | ($random(stim_seed) & 32'h0000_03fc);
            wdata = $random(stim_seed);
            pick  = $random(stim_seed);
            cpu_access(addr, wdata, pick[0]);
        end
        check_counters();
        run_flush();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== bench/mem_model.sv ====
`timescale 1ns/1ps

module mem_model (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mem_valid,
    input  cache_pkg::mem_req_t           mem_req,
    output logic                          mem_ack,
    output logic [cache_pkg::BLOCK_W-1:0] mem_rdata
);
    import cache_pkg::*;

    logic [BLOCK_W-1:0] blocks [logic [ADDR_W-1:0]];  // Only blocks written so far
    integer             seed = 20429;
    int                 delay;

    // Contents of a block never written, spread over the whole address
    function automatic logic [BLOCK_W-1:0] initial_block(input logic [ADDR_W-1:0] ba);
        logic [BLOCK_W-1:0] blk;
        for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
            blk[i*WORD_W +: WORD_W] = (ba + 4*i) * 32'h9e37_79b9 + 32'h0bad_c0de;
        end
        return blk;
    endfunction

    initial begin
        mem_ack   = 1'b0;
        mem_rdata = '0;
        delay     = 0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst || mem_ack) begin
                mem_ack = 1'b0;                  // Ack lasts one cycle
                delay   = $random(seed) & 3;
            end else if (mem_valid && delay > 0) begin
                delay = delay - 1;
            end else if (mem_valid) begin
                if (mem_req.write) begin
                    blocks[mem_req.addr] = mem_req.wdata;
                end else if (blocks.exists(mem_req.addr)) begin
                    mem_rdata = blocks[mem_req.addr];
                end else begin
                    mem_rdata = initial_block(mem_req.addr);
                end
                mem_ack = 1'b1;
            end
        end
    end

endmodule

// ==== logic/cache_top.sv ====
`timescale 1ns/1ps

module cache_top #(
    parameter int NUM_LINES = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    // CPU port
    input  logic                          cpu_valid,
    input  cache_pkg::cpu_req_t           cpu_req,
    output logic                          cpu_ready,
    output logic                          cpu_done,
    output logic [cache_pkg::WORD_W-1:0]  cpu_rdata,
    // Memory port
    output logic                          mem_valid,
    output cache_pkg::mem_req_t           mem_req,
    input  logic                          mem_ack,
    input  logic [cache_pkg::BLOCK_W-1:0] mem_rdata,
    // Register port
    input  logic                          csr_valid,
    input  logic                          csr_write,
    input  logic [3:0]                    csr_addr,
    input  logic [cache_pkg::WORD_W-1:0]  csr_wdata,
    output logic [cache_pkg::WORD_W-1:0]  csr_rdata
);
    import cache_pkg::*;

    localparam int IDX_W = $clog2(NUM_LINES);

    // Register block to controller
    logic enable;
    logic flush_start;
    logic flush_busy;
    logic hit_event;
    logic miss_event;

    // Controller to datapath
    logic [ADDR_W-1:0] dp_addr;
    logic [WORD_W-1:0] dp_wdata;
    logic              lookup;
    logic              write_word;
    logic              fill;
    logic              clear_line;
    logic              flush_sel;
    logic [IDX_W-1:0]  flush_index;

    // Datapath status
    logic               hit;
    logic               dirty;
    logic [ADDR_W-1:0]  victim_addr;
    logic [BLOCK_W-1:0] line_data;
    logic [WORD_W-1:0]  rdata;

    cache_controller #(
        .NUM_LINES(NUM_LINES)
    ) controller_inst (
        .clk        (clk),
        .rst        (rst),
        .cpu_valid  (cpu_valid),
        .cpu_req    (cpu_req),
        .cpu_ready  (cpu_ready),
        .cpu_done   (cpu_done),
        .cpu_rdata  (cpu_rdata),
        .mem_valid  (mem_valid),
        .mem_req    (mem_req),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .enable     (enable),
        .flush_start(flush_start),
        .flush_busy (flush_busy),
        .hit_event  (hit_event),
        .miss_event (miss_event),
        .dp_addr    (dp_addr),
        .dp_wdata   (dp_wdata),
        .lookup     (lookup),
        .write_word (write_word),
        .fill       (fill),
        .clear_line (clear_line),
        .flush_sel  (flush_sel),
        .flush_index(flush_index),
        .hit        (hit),
        .dirty      (dirty),
        .victim_addr(victim_addr),
        .line_data  (line_data),
        .rdata      (rdata)
    );

    cache_datapath #(
        .NUM_LINES(NUM_LINES)
    ) datapath_inst (
        .clk        (clk),
        .rst        (rst),
        .addr       (dp_addr),
        .wdata      (dp_wdata),
        .lookup     (lookup),
        .write_word (write_word),
        .fill       (fill),
        .fill_data  (mem_rdata),   // Fills come straight off the memory port
        .clear_line (clear_line),
        .flush_sel  (flush_sel),
        .flush_index(flush_index),
        .hit        (hit),
        .dirty      (dirty),
        .victim_addr(victim_addr),
        .line_data  (line_data),
        .rdata      (rdata)
    );

    cache_csr csr_inst (
        .clk        (clk),
        .rst        (rst),
        .csr_valid  (csr_valid),
        .csr_write  (csr_write),
        .csr_addr   (csr_addr),
        .csr_wdata  (csr_wdata),
        .flush_busy (flush_busy),
        .hit_event  (hit_event),
        .miss_event (miss_event),
        .csr_rdata  (csr_rdata),
        .enable     (enable),
        .flush_start(flush_start)
    );

endmodule

// ==== logic/cache_csr.sv ====
`timescale 1ns/1ps

module cache_csr (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         csr_valid,
    input  logic                         csr_write,
    input  logic [3:0]                   csr_addr,
    input  logic [cache_pkg::WORD_W-1:0] csr_wdata,
    input  logic                         flush_busy,
    input  logic                         hit_event,
    input  logic                         miss_event,
    output logic [cache_pkg::WORD_W-1:0] csr_rdata,
    output logic                         enable,
    output logic                         flush_start
);
    import cache_pkg::*;

    logic              wr_en;
    logic              wr_ctrl;
    logic [WORD_W-1:0] count [2];    // Entry 0 hits, entry 1 misses
    logic [1:0]        count_evt;
    logic [1:0]        count_clr;

    assign wr_en   = csr_valid && csr_write;
    assign wr_ctrl = wr_en && (csr_addr == CSR_CTRL);

    assign count_evt = {miss_event, hit_event};
    assign count_clr = {wr_en && (csr_addr == CSR_MISSES), wr_en && (csr_addr == CSR_HITS)};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            enable      <= 1'b1;   // Cache on out of reset
            flush_start <= 1'b0;
        end else begin
            flush_start <= wr_ctrl && csr_wdata[1];  // One cycle pulse
            if (wr_ctrl) begin
                enable <= csr_wdata[0];
            end
        end
    end

    // Saturating event counters
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count[0] <= '0;
            count[1] <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (count_clr[i]) begin
                    count[i] <= '0;
                end else if (count_evt[i] && (count[i] != '1)) begin
                    count[i] <= count[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (csr_addr)
            CSR_CTRL:   csr_rdata = {{(WORD_W-1){1'b0}}, enable};  // Flush bit reads 0
            CSR_STATUS: csr_rdata = {{(WORD_W-1){1'b0}}, flush_busy};
            CSR_HITS:   csr_rdata = count[0];
            CSR_MISSES: csr_rdata = count[1];
            default:    csr_rdata = '0;
        endcase
    end

endmodule

// ==== logic/cache_controller.sv ====
`timescale 1ns/1ps

module cache_controller #(
    parameter int NUM_LINES = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    // CPU side
    input  logic                          cpu_valid,
    input  cache_pkg::cpu_req_t           cpu_req,
    output logic                          cpu_ready,
    output logic                          cpu_done,
    output logic [cache_pkg::WORD_W-1:0]  cpu_rdata,
    // Memory side
    output logic                          mem_valid,
    output cache_pkg::mem_req_t           mem_req,
    input  logic                          mem_ack,
    input  logic [cache_pkg::BLOCK_W-1:0] mem_rdata,
    // Register block
    input  logic                          enable,
    input  logic                          flush_start,
    output logic                          flush_busy,
    output logic                          hit_event,
    output logic                          miss_event,
    // Datapath
    output logic [cache_pkg::ADDR_W-1:0]  dp_addr,
    output logic [cache_pkg::WORD_W-1:0]  dp_wdata,
    output logic                          lookup,
    output logic                          write_word,
    output logic                          fill,
    output logic                          clear_line,
    output logic                          flush_sel,
    output logic [$clog2(NUM_LINES)-1:0]  flush_index,
    input  logic                          hit,
    input  logic                          dirty,
    input  logic [cache_pkg::ADDR_W-1:0]  victim_addr,
    input  logic [cache_pkg::BLOCK_W-1:0] line_data,
    input  logic [cache_pkg::WORD_W-1:0]  rdata
);
    import cache_pkg::*;

    localparam int IDX_W = $clog2(NUM_LINES);

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_write_back,
        st_allocate,
        st_unc_write,   // Uncached write of the merged block
        st_done,
        st_flush_walk,
        st_flush_wb
    } state_t;

    state_t state;
    state_t state_next;

    cpu_req_t          req_q;
    logic              uncached_q;  // Request taken with the cache disabled
    logic              flush_pend;
    logic [IDX_W-1:0]  flush_idx;
    logic [WORD_W-1:0] unc_rdata;
    logic              last_line;

    mem_req_t fetch_req;
    mem_req_t mem_next;
    logic     mem_load;

    assign dp_addr     = req_q.addr;
    assign dp_wdata    = req_q.wdata;
    assign flush_index = flush_idx;
    assign last_line   = (flush_idx == IDX_W'(NUM_LINES - 1));

    assign fetch_req = '{addr: block_addr(req_q.addr), wdata: '0, write: 1'b0};

    assign flush_sel  = (state == st_flush_walk) || (state == st_flush_wb);
    assign flush_busy = flush_pend || flush_sel;
    assign cpu_ready  = (state == st_idle) && !flush_pend && !flush_start;

    assign lookup     = (state == st_compare) && !uncached_q;
    assign hit_event  = lookup && hit;
    assign miss_event = (state == st_compare) && !hit;  // Uncached requests count too

    assign fill       = (state == st_allocate) && !uncached_q && mem_ack;
    assign write_word = req_q.write && (hit_event || fill);
    assign clear_line = ((state == st_flush_walk) && !dirty) ||
                        ((state == st_flush_wb) && mem_ack);

    assign cpu_done  = hit_event || (state == st_done);
    assign cpu_rdata = uncached_q ? unc_rdata : rdata;

    always_comb begin
        state_next = state;
        mem_load   = 1'b0;
        mem_next   = fetch_req;

        case (state)
            st_idle: begin
                if (flush_start || flush_pend) begin
                    state_next = st_flush_walk;
                end else if (cpu_valid) begin
                    state_next = st_compare;
                end
            end
            st_compare: begin
                if (hit_event) begin
                    state_next = st_idle;
                end else if (lookup && dirty) begin
                    mem_load   = 1'b1;
                    mem_next   = '{addr: victim_addr, wdata: line_data, write: 1'b1};
                    state_next = st_write_back;
                end else begin
                    mem_load   = 1'b1;
                    state_next = st_allocate;
                end
            end
            st_write_back: begin
                if (mem_ack) begin
                    mem_load   = 1'b1;   // Fill read follows straight on
                    state_next = st_allocate;
                end
            end
            st_allocate: begin
                if (mem_ack && uncached_q && req_q.write) begin
                    mem_load   = 1'b1;
                    mem_next   = '{addr:  fetch_req.addr,
                                   wdata: put_word(mem_rdata, word_sel(req_q.addr),
                                                   req_q.wdata),
                                   write: 1'b1};
                    state_next = st_unc_write;
                end else if (mem_ack) begin
                    state_next = st_done;
                end
            end
            st_unc_write: begin
                if (mem_ack) begin
                    state_next = st_done;
                end
            end
            st_done: state_next = st_idle;
            st_flush_walk: begin
                if (dirty) begin
                    mem_load   = 1'b1;
                    mem_next   = '{addr: victim_addr, wdata: line_data, write: 1'b1};
                    state_next = st_flush_wb;
                end else if (last_line) begin
                    state_next = st_idle;
                end
            end
            st_flush_wb: begin
                if (mem_ack) begin
                    state_next = last_line ? st_idle : st_flush_walk;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= st_idle;
            uncached_q <= 1'b0;
            flush_pend <= 1'b0;
            flush_idx  <= '0;
            mem_valid  <= 1'b0;
        end else begin
            state <= state_next;

            if (cpu_valid && cpu_ready) begin
                uncached_q <= !enable;
            end

            // Flush asked for in mid request waits for idle
            if (state == st_idle) begin
                flush_pend <= 1'b0;
            end else if (flush_start && !flush_sel) begin
                flush_pend <= 1'b1;
            end

            if (state == st_idle) begin
                flush_idx <= '0;
            end else if (clear_line) begin
                flush_idx <= flush_idx + 1'b1;
            end

            if (mem_load) begin
                mem_valid <= 1'b1;
            end else if (mem_ack) begin
                mem_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_valid && cpu_ready) begin
            req_q <= cpu_req;
        end
        if (mem_load) begin
            mem_req <= mem_next;
        end
        if ((state == st_allocate) && mem_ack) begin
            unc_rdata <= get_word(mem_rdata, word_sel(req_q.addr));
        end
    end

endmodule

// ==== logic/cache_datapath.sv ====
`timescale 1ns/1ps

module cache_datapath #(
    parameter int NUM_LINES = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [cache_pkg::ADDR_W-1:0]  addr,
    input  logic [cache_pkg::WORD_W-1:0]  wdata,
    input  logic                          lookup,
    input  logic                          write_word,
    input  logic                          fill,
    input  logic [cache_pkg::BLOCK_W-1:0] fill_data,
    input  logic                          clear_line,
    input  logic                          flush_sel,
    input  logic [$clog2(NUM_LINES)-1:0]  flush_index,
    output logic                          hit,
    output logic                          dirty,
    output logic [cache_pkg::ADDR_W-1:0]  victim_addr,
    output logic [cache_pkg::BLOCK_W-1:0] line_data,
    output logic [cache_pkg::WORD_W-1:0]  rdata
);
    import cache_pkg::*;

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W;

    // Line storage
    logic [TAG_W-1:0]     tag_array  [NUM_LINES];
    logic [BLOCK_W-1:0]   data_array [NUM_LINES];
    logic [NUM_LINES-1:0] valid_bits;
    logic [NUM_LINES-1:0] dirty_bits;

    // Address fields
    logic [TAG_W-1:0] addr_tag;
    logic [IDX_W-1:0] addr_index;
    logic [IDX_W-1:0] index;       // Line that every port below refers to

    logic [BLOCK_W-1:0] write_block;
    logic               tag_match;

    assign addr_tag   = addr[ADDR_W-1 -: TAG_W];
    assign addr_index = addr[OFFSET_W +: IDX_W];
    assign index      = flush_sel ? flush_index : addr_index;

    assign line_data = data_array[index];
    assign rdata     = get_word(line_data, word_sel(addr));

    assign tag_match = (tag_array[index] == addr_tag);
    assign hit       = lookup && valid_bits[index] && tag_match;
    assign dirty     = valid_bits[index] && dirty_bits[index];

    // Block address of whatever the selected line holds now
    assign victim_addr = {tag_array[index], index, {OFFSET_W{1'b0}}};

    // Write miss: the CPU word lands on top of the incoming block
    assign write_block = put_word(fill ? fill_data : line_data, word_sel(addr), wdata);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (clear_line) begin
            valid_bits[index] <= 1'b0;
            dirty_bits[index] <= 1'b0;
        end else if (fill) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= write_word;  // Clean unless a write rides along
        end else if (write_word) begin
            dirty_bits[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_array[index] <= addr_tag;
        end

        if (write_word) begin
            data_array[index] <= write_block;
        end else if (fill) begin
            data_array[index] <= fill_data;
        end
    end

endmodule

// ==== logic/cache_pkg.sv ====
package cache_pkg;

    localparam int ADDR_W  = 32;
    localparam int WORD_W  = 32;
    localparam int BLOCK_W = 128;

    localparam int WORDS_PER_BLOCK = BLOCK_W / WORD_W;
    localparam int OFFSET_W        = $clog2(BLOCK_W / 8);  // Byte offset inside a line
    localparam int WSEL_W          = $clog2(WORDS_PER_BLOCK);

    // One CPU request
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
        logic              write;
    } cpu_req_t;

    // One memory request, always a whole block
    typedef struct packed {
        logic [ADDR_W-1:0]  addr;   // Block aligned
        logic [BLOCK_W-1:0] wdata;
        logic               write;
    } mem_req_t;

    localparam logic [3:0] CSR_CTRL   = 4'h0;
    localparam logic [3:0] CSR_STATUS = 4'h4;
    localparam logic [3:0] CSR_HITS   = 4'h8;
    localparam logic [3:0] CSR_MISSES = 4'hc;

    function automatic logic [WSEL_W-1:0] word_sel(input logic [ADDR_W-1:0] addr);
        return addr[OFFSET_W-1 -: WSEL_W];
    endfunction

    function automatic logic [ADDR_W-1:0] block_addr(input logic [ADDR_W-1:0] addr);
        return {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    endfunction

    function automatic logic [WORD_W-1:0] get_word(input logic [BLOCK_W-1:0] block,
                                                   input logic [WSEL_W-1:0]  sel);
        return block[sel*WORD_W +: WORD_W];
    endfunction

    // Replace one word of a block
    function automatic logic [BLOCK_W-1:0] put_word(input logic [BLOCK_W-1:0] block,
                                                    input logic [WSEL_W-1:0]  sel,
                                                    input logic [WORD_W-1:0]  word);
        logic [BLOCK_W-1:0] merged;
        merged = block;
        merged[sel*WORD_W +: WORD_W] = word;
        return merged;
    endfunction

endpackage
